// ==== cce_inst_decode.f ====
rtl/cce_isa_pkg.sv
rtl/cce_ctrl_pkg.sv
rtl/cce_exec_stage.sv
rtl/cce_alu_decode.sv
rtl/cce_branch_decode.sv
rtl/cce_move_decode.sv
rtl/cce_decode_select.sv
rtl/cce_inst_decode.sv
tb/cce_inst_decode_sva.sv
tb/cce_inst_decode_tb.sv

// ==== Makefile ====
# Verilator build and run of the execute-stage decoder testbench
VERILATOR ?= verilator
TOP       ?= cce_inst_decode_tb
FLIST     ?= cce_inst_decode.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST PASS

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(wildcard rtl/*.sv tb/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# the run fails unless the pass line shows up in the output
run: compile
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/cce_inst_decode_tb.sv ====
/*
  testbench for the execute-stage instruction decoder
  builds a table of instructions with the expected control word and PC,
  then applies one row per cycle and checks each row one cycle later
*/
`timescale 1ns/100ps

module cce_inst_decode_tb
  import cce_isa_pkg::*;
  import cce_ctrl_pkg::*;
  ();

  localparam int pc_width = 8;
  localparam int reset_cycles = 5;
  localparam int timeout_margin = 20;

  logic                clk_i;
  logic                reset_i;
  cce_inst_s           inst_i;
  logic [pc_width-1:0] pc_i;
  logic                inst_v_i;
  logic                stall_i;
  logic                mispredict_i;
  decoded_inst_s       decoded_inst_o;
  logic [pc_width-1:0] pc_o;

  // stimulus and expected values, one entry per cycle
  logic [inst_width-1:0] row_inst[$];
  logic [pc_width-1:0]   row_pc[$];
  logic                  row_v[$];
  logic                  row_stall[$];
  logic                  row_misp[$];
  decoded_inst_s         row_exp[$];
  logic [pc_width-1:0]   row_exp_pc[$];

  // what the outputs show while a stall is held
  decoded_inst_s       held_word;
  logic [pc_width-1:0] held_pc;

  integer seed;
  int     cycles;
  int     cycle_limit;

  cce_inst_decode #(
    .pc_width_p(pc_width)
  ) uut (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .inst_i        (inst_i),
    .pc_i          (pc_i),
    .inst_v_i      (inst_v_i),
    .stall_i       (stall_i),
    .mispredict_i  (mispredict_i),
    .decoded_inst_o(decoded_inst_o),
    .pc_o          (pc_o)
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: the test did not finish within %0d cycles", cycle_limit);
      $display("TEST FAIL");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check_value(input string what, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("TEST FAIL");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  function automatic decoded_inst_s base_word(input cce_op_e op, input logic [3:0] minor);
    decoded_inst_s word;
    word = '0;
    word.v = 1'b1;
    word.op = op;
    word.minor_op = minor;
    return word;
  endfunction

  task automatic add_row(input logic [inst_width-1:0] inst, input logic v, input logic stall,
                         input logic misp, input decoded_inst_s exp);
    logic [pc_width-1:0] pc;
    pc = pc_width'($random(seed));
    row_inst.push_back(inst);
    row_pc.push_back(pc);
    row_v.push_back(v);
    row_stall.push_back(stall);
    row_misp.push_back(misp);
    // a stalled register keeps the word and PC of the last unstalled row
    if (!stall) begin
      held_word = exp;
      held_pc = pc;
    end
    row_exp.push_back(held_word);
    row_exp_pc.push_back(held_pc);
  endtask

  task automatic alu_row(input logic [3:0] minor, input alu_op_e alu_op, input src_sel_e b_sel,
                         input logic [3:0] dst, input logic [3:0] a, input logic [3:0] b,
                         input logic [15:0] imm, input logic [7:0] gpr_w);
    decoded_inst_s         exp;
    logic [inst_width-1:0] inst;
    exp = base_word(op_alu, minor);
    exp.alu_op = alu_op;
    exp.src_a_sel = src_sel_gpr;
    exp.src_a = a;
    exp.src_b_sel = b_sel;
    exp.dst_sel = dst_sel_gpr;
    exp.dst = dst;
    exp.gpr_w_v = gpr_w;
    if (b_sel == src_sel_imm) begin
      inst = {op_alu, minor, 2'b00, dst, imm, 3'h0};
      exp.imm = imm;
    end else begin
      inst = {op_alu, minor, 2'b00, dst, a, b, 11'h0};
      // neg and not leave src_b empty
      if (b_sel == src_sel_gpr) begin
        exp.src_b = b;
      end
    end
    add_row(inst, 1'b1, 1'b0, 1'b0, exp);
  endtask

  task automatic branch_row(input logic [3:0] minor, input branch_op_e br_op,
                            input src_sel_e a_sel, input src_sel_e b_sel,
                            input logic [3:0] a, input logic [3:0] b, input logic [7:0] imm,
                            input logic [7:0] target, input logic br, input logic pt);
    decoded_inst_s         exp;
    logic [inst_width-1:0] inst;
    exp = base_word(op_branch, minor);
    exp.branch = br;
    exp.predict_taken = pt;
    exp.branch_op = br_op;
    exp.src_a_sel = a_sel;
    exp.src_a = a;
    exp.src_b_sel = b_sel;
    exp.branch_target = target;
    if (b_sel == src_sel_imm) begin
      inst = {op_branch, minor, br, pt, a, imm, target, 3'h0};
      exp.imm = {8'h00, imm};
    end else begin
      inst = {op_branch, minor, br, pt, a, b, target, 7'h0};
      exp.src_b = b;
    end
    add_row(inst, 1'b1, 1'b0, 1'b0, exp);
  endtask

  task automatic move_row(input logic [3:0] minor, input src_sel_e a_sel, input dst_sel_e d_sel,
                          input logic [3:0] dst, input logic [3:0] a, input logic [15:0] imm,
                          input logic [7:0] gpr_w, input logic [3:0] special_w);
    decoded_inst_s         exp;
    logic [inst_width-1:0] inst;
    exp = base_word(op_move, minor);
    exp.src_a_sel = a_sel;
    exp.dst_sel = d_sel;
    exp.dst = dst;
    exp.gpr_w_v = gpr_w;
    exp.special_w_v = special_w;
    if (a_sel == src_sel_imm) begin
      inst = {op_move, minor, 2'b00, dst, imm, 3'h0};
      exp.imm = imm;
    end else begin
      inst = {op_move, minor, 2'b00, dst, a, 4'hf, 11'h0};
      exp.src_a = a;
    end
    add_row(inst, 1'b1, 1'b0, 1'b0, exp);
  endtask

  initial begin
    decoded_inst_s invalid_word;
    seed = 32'h6a6a8928;
    cycles = 0;
    clk_i = 1'b0;
    reset_i = 1'b1;
    // a valid move with a nonzero PC waits at the inputs while reset is held
    inst_i = cce_inst_s'({op_move, movi_op, 2'b00, 23'h5a5a5a});
    pc_i = '1;
    inst_v_i = 1'b1;
    stall_i = 1'b0;
    mispredict_i = 1'b0;
    held_word = '0;
    held_pc = '0;
    invalid_word = '0;
    invalid_word.v = 1'b1;

    // ALU register, one-operand and immediate forms
    alu_row(add_op, alu_add, src_sel_gpr, 4'd1, 4'd2, 4'd3, 16'h0, 8'h02);
    alu_row(sub_op, alu_sub, src_sel_gpr, 4'd2, 4'd3, 4'd4, 16'h0, 8'h04);
    alu_row(lsh_op, alu_lsh, src_sel_gpr, 4'd3, 4'd4, 4'd5, 16'h0, 8'h08);
    alu_row(rsh_op, alu_rsh, src_sel_gpr, 4'd4, 4'd5, 4'd6, 16'h0, 8'h10);
    alu_row(and_op, alu_and, src_sel_gpr, 4'd5, 4'd6, 4'd7, 16'h0, 8'h20);
    alu_row(or_op, alu_or, src_sel_gpr, 4'd6, 4'd7, 4'd0, 16'h0, 8'h40);
    alu_row(xor_op, alu_xor, src_sel_gpr, 4'd7, 4'd0, 4'd1, 16'h0, 8'h80);
    alu_row(neg_op, alu_neg, src_sel_none, 4'd0, 4'd1, 4'd5, 16'h0, 8'h01);
    alu_row(not_op, alu_not, src_sel_none, 4'd9, 4'd3, 4'd6, 16'h0, 8'h02);
    alu_row(addi_op, alu_add, src_sel_imm, 4'd2, 4'd2, 4'd0, 16'h1234, 8'h04);
    alu_row(subi_op, alu_sub, src_sel_imm, 4'd3, 4'd3, 4'd0, 16'h00ff, 8'h08);
    alu_row(lshi_op, alu_lsh, src_sel_imm, 4'd4, 4'd4, 4'd0, 16'h0004, 8'h10);
    alu_row(rshi_op, alu_rsh, src_sel_imm, 4'd5, 4'd5, 4'd0, 16'h8001, 8'h20);

    // branches, immediate forms zero-extend the 8-bit value
    branch_row(beq_op, branch_eq, src_sel_gpr, src_sel_gpr, 4'd1, 4'd2, 8'h0, 8'h10, 1, 0);
    branch_row(bne_op, branch_neq, src_sel_gpr, src_sel_gpr, 4'd3, 4'd4, 8'h0, 8'h20, 1, 1);
    branch_row(blt_op, branch_lt, src_sel_gpr, src_sel_gpr, 4'd5, 4'd6, 8'h0, 8'h30, 0, 1);
    branch_row(ble_op, branch_le, src_sel_gpr, src_sel_gpr, 4'd7, 4'd0, 8'h0, 8'h40, 1, 1);
    branch_row(bs_op, branch_eq, src_sel_special, src_sel_gpr, 4'd2, 4'd3, 8'h0, 8'h50, 1, 0);
    branch_row(bss_op, branch_eq, src_sel_special, src_sel_special, 4'd1, 4'd3, 8'h0, 8'h60,
               0, 0);
    branch_row(beqi_op, branch_eq, src_sel_gpr, src_sel_imm, 4'd4, 4'd0, 8'ha5, 8'h70, 1, 1);
    branch_row(bsi_op, branch_eq, src_sel_special, src_sel_imm, 4'd3, 4'd0, 8'h3c, 8'h80, 1, 0);

    // moves, with every special register as a destination
    move_row(mov_op, src_sel_gpr, dst_sel_gpr, 4'd6, 4'd1, 16'h0, 8'h40, 4'h0);
    move_row(movsg_op, src_sel_special, dst_sel_gpr, 4'd2, 4'd3, 16'h0, 8'h04, 4'h0);
    move_row(movi_op, src_sel_imm, dst_sel_gpr, 4'd7, 4'd0, 16'hcafe, 8'h80, 4'h0);
    for (int s = 0; s < num_special; s++) begin
      move_row(movgs_op, src_sel_gpr, dst_sel_special, 4'(s), 4'd5, 16'h0, 8'h00,
               4'(1 << s));
      move_row(movis_op, src_sel_imm, dst_sel_special, 4'(s + 4), 4'd0,
               16'(16'h0100 + s), 8'h00, 4'(1 << s));
    end

    // stall held over random inputs, then released
    alu_row(xor_op, alu_xor, src_sel_gpr, 4'd3, 4'd1, 4'd2, 16'h0, 8'h08);
    repeat (3) add_row(inst_width'($random(seed)), 1'b1, 1'b1, 1'b0, '0);
    move_row(movi_op, src_sel_imm, dst_sel_gpr, 4'd1, 4'd0, 16'h7777, 8'h02, 4'h0);

    // squash, invalid input and invalid op class
    add_row({op_alu, add_op, 2'b00, 23'h123456}, 1'b1, 1'b0, 1'b1, '0);
    add_row({op_move, mov_op, 2'b00, 23'h654321}, 1'b0, 1'b0, 1'b0, '0);
    add_row({3'b111, 4'h3, 2'b11, 23'h7fffff}, 1'b1, 1'b0, 1'b0, invalid_word);
    alu_row(add_op, alu_add, src_sel_gpr, 4'd7, 4'd6, 4'd5, 16'h0, 8'h80);

    cycle_limit = row_inst.size() + reset_cycles + timeout_margin;

    repeat (reset_cycles) @(negedge clk_i);
    check_value("decoded word after reset", 128'(decoded_inst_o), 128'h0);
    check_value("pc after reset", 128'(pc_o), 128'h0);
    reset_i = 1'b0;

    foreach (row_inst[i]) begin
      inst_i = cce_inst_s'(row_inst[i]);
      pc_i = row_pc[i];
      inst_v_i = row_v[i];
      stall_i = row_stall[i];
      mispredict_i = row_misp[i];
      @(negedge clk_i);
      check_value($sformatf("row %0d decoded word", i), 128'(decoded_inst_o),
                  128'(row_exp[i]));
      check_value($sformatf("row %0d pc", i), 128'(pc_o), 128'(row_exp_pc[i]));
    end

    if (uut.sva.fail_count == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("%0d assertion failures in the bound checker", uut.sva.fail_count);
      $display("TEST FAIL");
      $fatal(1, "bound assertions failed");
    end
  end

endmodule

// ==== tb/cce_inst_decode_sva.sv ====
/*
  concurrent assertions bound into the decoder top level
  checks invalid-word gating, one-hot write enables and the stall hold
*/
`timescale 1ns/100ps

module cce_inst_decode_sva
  import cce_ctrl_pkg::*;
  #(parameter int pc_width_p = 8
  )
  (input                     clk_i
   , input                   reset_i
   , input                   stall_i
   , input  decoded_inst_s   decoded_i
   , input  [pc_width_p-1:0] pc_i
  );

  int fail_count = 0;

  // an invalid instruction carries no control at all
  invalid_zero_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !decoded_i.v |-> decoded_i == '0)
    else begin
      fail_count++;
      $error("decoded word has fields set while v is low");
    end

  write_onehot_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(decoded_i.gpr_w_v) && $onehot0(decoded_i.special_w_v))
    else begin
      fail_count++;
      $error("write enables are not zero or one-hot");
    end

  stall_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    stall_i |=> $stable(decoded_i) && $stable(pc_i))
    else begin
      fail_count++;
      $error("decoded word or pc changed under stall");
    end

endmodule

bind cce_inst_decode cce_inst_decode_sva #(
  .pc_width_p(pc_width_p)
) sva (
  .clk_i    (clk_i),
  .reset_i  (reset_i),
  .stall_i  (stall_i),
  .decoded_i(decoded_inst_o),
  .pc_i     (pc_o)
);

// ==== rtl/cce_inst_decode.sv ====
/*
  execute-stage instruction decoder of the coherence engine
  registers the fetched instruction and decodes it into one control word
  decoded_inst_o and pc_o follow an unstalled input by one cycle
*/
`timescale 1ns/100ps

module cce_inst_decode
  import cce_isa_pkg::*;
  import cce_ctrl_pkg::*;
  #(parameter int pc_width_p = 8
  )
  (input                           clk_i
   , input                         reset_i
   , input  cce_inst_s             inst_i
   , input  [pc_width_p-1:0]       pc_i
   , input                         inst_v_i
   , input                         stall_i
   , input                         mispredict_i
   , output decoded_inst_s         decoded_inst_o
   , output logic [pc_width_p-1:0] pc_o
  );

  cce_inst_s             inst_r;
  logic [pc_width_p-1:0] pc_r;
  logic                  inst_v_r;
  decoded_inst_s         alu_dec;
  decoded_inst_s         branch_dec;
  decoded_inst_s         move_dec;

  cce_exec_stage #(
    .pc_width_p(pc_width_p)
  ) exec_stage (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .inst_i      (inst_i),
    .pc_i        (pc_i),
    .inst_v_i    (inst_v_i),
    .stall_i     (stall_i),
    .mispredict_i(mispredict_i),
    .inst_o      (inst_r),
    .pc_o        (pc_r),
    .inst_v_o    (inst_v_r)
  );

  // all three class decoders see every instruction
  cce_alu_decode alu_decode (
    .inst_i   (inst_r),
    .decoded_o(alu_dec)
  );

  cce_branch_decode branch_decode (
    .inst_i   (inst_r),
    .decoded_o(branch_dec)
  );

  cce_move_decode move_decode (
    .inst_i   (inst_r),
    .decoded_o(move_dec)
  );

  cce_decode_select decode_select (
    .inst_i      (inst_r),
    .inst_v_i    (inst_v_r),
    .alu_dec_i   (alu_dec),
    .branch_dec_i(branch_dec),
    .move_dec_i  (move_dec),
    .decoded_o   (decoded_inst_o)
  );

  assign pc_o = pc_r;

endmodule

// ==== rtl/cce_decode_select.sv ====
/*
  picks the class decoder output that matches the op class
  an unknown class or an invalid instruction gives an all-zero word
  and v always follows the registered valid bit
*/
`timescale 1ns/100ps

module cce_decode_select
  import cce_isa_pkg::*;
  import cce_ctrl_pkg::*;
  (input  cce_inst_s      inst_i
   , input                inst_v_i
   , input  decoded_inst_s alu_dec_i
   , input  decoded_inst_s branch_dec_i
   , input  decoded_inst_s move_dec_i
   , output decoded_inst_s decoded_o
  );

  always_comb begin
    decoded_o = '0;
    if (inst_v_i) begin
      unique case (inst_i.op)
        op_alu:    decoded_o = alu_dec_i;
        op_branch: decoded_o = branch_dec_i;
        op_move:   decoded_o = move_dec_i;
        default:   decoded_o = '0;
      endcase
      decoded_o.v = 1'b1;
    end
  end

endmodule

// ==== rtl/cce_move_decode.sv ====
/*
  register move class decoder
  covers moves between GPRs and special registers and immediate loads
  a special destination raises the one-hot write enable of that register
*/
`timescale 1ns/100ps

module cce_move_decode
  import cce_isa_pkg::*;
  import cce_ctrl_pkg::*;
  (input  cce_inst_s      inst_i
   , output decoded_inst_s decoded_o
  );

  move_minor_e          minor;
  rtype_s               rtype;
  itype_s               itype;
  src_sel_e             a_sel;
  dst_sel_e             d_sel;
  logic [opd_width-1:0] dst;
  special_e             special;

  always_comb begin
    minor = move_minor_e'(inst_i.minor_op);
    rtype = rtype_s'(inst_i.body);
    itype = itype_s'(inst_i.body);

    unique case (minor)
      mov_op, movgs_op:  a_sel = src_sel_gpr;
      movsg_op:          a_sel = src_sel_special;
      movi_op, movis_op: a_sel = src_sel_imm;
      default:           a_sel = src_sel_none;
    endcase

    unique case (minor)
      mov_op, movsg_op, movi_op: d_sel = dst_sel_gpr;
      movgs_op, movis_op:        d_sel = dst_sel_special;
      default:                   d_sel = dst_sel_none;
    endcase

    // dst is in the same place for r-type and i-type
    dst = rtype.dst;
    special = special_e'(dst[special_sel_width-1:0]);

    decoded_o = '0;
    decoded_o.op = inst_i.op;
    decoded_o.minor_op = inst_i.minor_op;
    decoded_o.src_a_sel = a_sel;
    decoded_o.dst_sel = d_sel;

    unique case (a_sel)
      src_sel_gpr, src_sel_special: begin
        decoded_o.src_a = rtype.src_a;
      end
      src_sel_imm: begin
        decoded_o.imm = itype.imm;
      end
      default: begin
      end
    endcase

    if (d_sel != dst_sel_none) begin
      decoded_o.dst = dst;
    end
    if (d_sel == dst_sel_gpr) begin
      decoded_o.gpr_w_v[dst[gpr_sel_width-1:0]] = 1'b1;
    end
    // req_lce, req_addr, req_way and next_coh_state each own one enable bit
    if (d_sel == dst_sel_special) begin
      decoded_o.special_w_v[special] = 1'b1;
    end
  end

endmodule

// ==== rtl/cce_branch_decode.sv ====
/*
  branch class decoder
  maps the compare-and-branch minor ops onto a compare op, two operand selects
  and a target, and carries the branch and predict-taken hints
*/
`timescale 1ns/100ps

module cce_branch_decode
  import cce_isa_pkg::*;
  import cce_ctrl_pkg::*;
  (input  cce_inst_s      inst_i
   , output decoded_inst_s decoded_o
  );

  branch_minor_e minor;
  btype_s        btype;
  bitype_s       bitype;
  branch_op_e    br_op;
  src_sel_e      a_sel;
  src_sel_e      b_sel;
  logic          imm_form;

  always_comb begin
    minor = branch_minor_e'(inst_i.minor_op);
    btype = btype_s'(inst_i.body);
    bitype = bitype_s'(inst_i.body);

    // only the plain gpr compares use something other than eq
    unique case (minor)
      bne_op:  br_op = branch_neq;
      blt_op:  br_op = branch_lt;
      ble_op:  br_op = branch_le;
      default: br_op = branch_eq;
    endcase

    unique case (minor)
      beq_op, bne_op, blt_op, ble_op, beqi_op: a_sel = src_sel_gpr;
      bs_op, bss_op, bsi_op:                   a_sel = src_sel_special;
      default:                                 a_sel = src_sel_none;
    endcase

    unique case (minor)
      beq_op, bne_op, blt_op, ble_op, bs_op: b_sel = src_sel_gpr;
      bss_op:                                b_sel = src_sel_special;
      beqi_op, bsi_op:                       b_sel = src_sel_imm;
      default:                               b_sel = src_sel_none;
    endcase

    imm_form = (b_sel == src_sel_imm);

    decoded_o = '0;
    decoded_o.op = inst_i.op;
    decoded_o.minor_op = inst_i.minor_op;
    // every known branch has a src_a, so a_sel doubles as the known flag
    if (a_sel != src_sel_none) begin
      decoded_o.branch = inst_i.branch;
      decoded_o.predict_taken = inst_i.predict_taken;
      decoded_o.branch_op = br_op;
      decoded_o.src_a_sel = a_sel;
      decoded_o.src_b_sel = b_sel;
      if (imm_form) begin
        decoded_o.src_a = bitype.src_a;
        decoded_o.imm = {{(imm16_width-imm8_width){1'b0}}, bitype.imm};
        decoded_o.branch_target = bitype.target;
      end else begin
        decoded_o.src_a = btype.src_a;
        decoded_o.src_b = btype.src_b;
        decoded_o.branch_target = btype.target;
      end
    end
  end

endmodule

// ==== rtl/cce_alu_decode.sv ====
/*
  ALU class decoder
  turns the register, immediate and one-operand ALU minor ops into a control word
  ignores the op class and the valid bit, the select stage takes care of both
*/
`timescale 1ns/100ps

module cce_alu_decode
  import cce_isa_pkg::*;
  import cce_ctrl_pkg::*;
  (input  cce_inst_s      inst_i
   , output decoded_inst_s decoded_o
  );

  alu_minor_e minor;
  rtype_s     rtype;
  itype_s     itype;
  alu_op_e    alu_op;
  src_sel_e   b_sel;
  logic       known;

  always_comb begin
    minor = alu_minor_e'(inst_i.minor_op);
    rtype = rtype_s'(inst_i.body);
    itype = itype_s'(inst_i.body);

    known = 1'b1;
    alu_op = alu_add;
    unique case (minor)
      add_op, addi_op: alu_op = alu_add;
      sub_op, subi_op: alu_op = alu_sub;
      lsh_op, lshi_op: alu_op = alu_lsh;
      rsh_op, rshi_op: alu_op = alu_rsh;
      and_op:          alu_op = alu_and;
      or_op:           alu_op = alu_or;
      xor_op:          alu_op = alu_xor;
      neg_op:          alu_op = alu_neg;
      not_op:          alu_op = alu_not;
      default:         known = 1'b0;
    endcase

    unique case (minor)
      addi_op, subi_op, lshi_op, rshi_op: b_sel = src_sel_imm;
      neg_op, not_op:                     b_sel = src_sel_none;
      default:                            b_sel = src_sel_gpr;
    endcase

    decoded_o = '0;
    decoded_o.op = inst_i.op;
    decoded_o.minor_op = inst_i.minor_op;
    if (known) begin
      decoded_o.alu_op = alu_op;
      decoded_o.dst_sel = dst_sel_gpr;
      decoded_o.dst = rtype.dst;
      decoded_o.gpr_w_v[rtype.dst[gpr_sel_width-1:0]] = 1'b1;
      decoded_o.src_a_sel = src_sel_gpr;
      // i-type has no src_a field, immediate forms update dst in place
      decoded_o.src_a = (b_sel == src_sel_imm) ? itype.dst : rtype.src_a;
      decoded_o.src_b_sel = b_sel;
      if (b_sel == src_sel_gpr) begin
        decoded_o.src_b = rtype.src_b;
      end
      if (b_sel == src_sel_imm) begin
        decoded_o.imm = itype.imm;
      end
    end
  end

endmodule

// ==== rtl/cce_exec_stage.sv ====
/*
  execute-stage register for instruction, PC and valid bit
  a stall holds all three, a mispredict squashes the incoming instruction
  outputs feed the combinational class decoders one cycle after sampling
*/
`timescale 1ns/100ps

module cce_exec_stage
  import cce_isa_pkg::*;
  #(parameter int pc_width_p = 8
  )
  (input                           clk_i
   , input                         reset_i
   , input  cce_inst_s             inst_i
   , input  [pc_width_p-1:0]       pc_i
   , input                         inst_v_i
   , input                         stall_i
   , input                         mispredict_i
   , output cce_inst_s             inst_o
   , output logic [pc_width_p-1:0] pc_o
   , output logic                  inst_v_o
  );

  cce_inst_s             inst_r;
  logic [pc_width_p-1:0] pc_r;
  logic                  inst_v_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      inst_r   <= '0;
      pc_r     <= '0;
      inst_v_r <= 1'b0;
    end else if (!stall_i) begin
      inst_r <= inst_i;
      pc_r   <= pc_i;
      // fetch is being redirected, so the instruction behind a mispredict is dropped
      inst_v_r <= mispredict_i ? 1'b0 : inst_v_i;
    end
  end

  assign inst_o   = inst_r;
  assign pc_o     = pc_r;
  assign inst_v_o = inst_v_r;

endmodule

// ==== rtl/cce_ctrl_pkg.sv ====
/*
  decoded control word of the execute stage
  the operand, destination, ALU and branch selects travel inside it
  to the register file, ALU and branch unit of the engine
*/
package cce_ctrl_pkg;

  import cce_isa_pkg::*;

  typedef enum logic [1:0] {
    src_sel_none    = 2'd0,
    src_sel_gpr     = 2'd1,
    src_sel_special = 2'd2,
    src_sel_imm     = 2'd3
  } src_sel_e;

  typedef enum logic [1:0] {
    dst_sel_none    = 2'd0,
    dst_sel_gpr     = 2'd1,
    dst_sel_special = 2'd2
  } dst_sel_e;

  // neg and not each get their own code, so nine codes need four bits
  typedef enum logic [3:0] {
    alu_add = 4'd0,
    alu_sub = 4'd1,
    alu_lsh = 4'd2,
    alu_rsh = 4'd3,
    alu_and = 4'd4,
    alu_or  = 4'd5,
    alu_xor = 4'd6,
    alu_neg = 4'd7,
    alu_not = 4'd8
  } alu_op_e;

  typedef enum logic [1:0] {
    branch_eq  = 2'd0,
    branch_neq = 2'd1,
    branch_lt  = 2'd2,
    branch_le  = 2'd3
  } branch_op_e;

  typedef struct packed {
    logic                    v;
    logic                    branch;
    logic                    predict_taken;
    cce_op_e                 op;
    logic [minor_width-1:0]  minor_op;
    alu_op_e                 alu_op;
    branch_op_e              branch_op;
    src_sel_e                src_a_sel;
    logic [opd_width-1:0]    src_a;
    src_sel_e                src_b_sel;
    logic [opd_width-1:0]    src_b;
    dst_sel_e                dst_sel;
    logic [opd_width-1:0]    dst;
    logic [imm16_width-1:0]  imm;
    logic [target_width-1:0] branch_target;
    // one-hot write enables, special_w_v is indexed by special_e
    logic [num_gpr-1:0]      gpr_w_v;
    logic [num_special-1:0]  special_w_v;
  } decoded_inst_s;

endpackage

// ==== rtl/cce_isa_pkg.sv ====
/*
  instruction encoding of the coherence engine microcode
  holds the op classes, the minor ops of each class, special register names
  and the four body layouts that the decoders cast the instruction body to
*/
package cce_isa_pkg;

  localparam int inst_width = 32;
  localparam int op_width = 3;
  localparam int minor_width = 4;
  // op class, minor op and the two hint bits sit above the body
  localparam int body_width = inst_width - op_width - minor_width - 2;

  localparam int opd_width = 4;
  localparam int gpr_sel_width = 3;
  localparam int num_gpr = 8;
  localparam int special_sel_width = 2;
  localparam int num_special = 4;
  localparam int imm16_width = 16;
  localparam int imm8_width = 8;
  localparam int target_width = 8;

  typedef enum logic [op_width-1:0] {
    op_alu    = 3'b000,
    op_branch = 3'b001,
    op_move   = 3'b010
  } cce_op_e;

  typedef enum logic [minor_width-1:0] {
    add_op  = 4'd0,
    sub_op  = 4'd1,
    lsh_op  = 4'd2,
    rsh_op  = 4'd3,
    and_op  = 4'd4,
    or_op   = 4'd5,
    xor_op  = 4'd6,
    neg_op  = 4'd7,
    addi_op = 4'd8,
    subi_op = 4'd9,
    lshi_op = 4'd10,
    rshi_op = 4'd11,
    not_op  = 4'd12
  } alu_minor_e;

  typedef enum logic [minor_width-1:0] {
    beq_op  = 4'd0,
    bne_op  = 4'd1,
    blt_op  = 4'd2,
    ble_op  = 4'd3,
    bs_op   = 4'd4,
    bss_op  = 4'd5,
    beqi_op = 4'd6,
    bsi_op  = 4'd7
  } branch_minor_e;

  typedef enum logic [minor_width-1:0] {
    mov_op   = 4'd0,
    movsg_op = 4'd1,
    movgs_op = 4'd2,
    movi_op  = 4'd3,
    movis_op = 4'd4
  } move_minor_e;

  typedef enum logic [special_sel_width-1:0] {
    req_lce        = 2'd0,
    req_addr       = 2'd1,
    req_way        = 2'd2,
    next_coh_state = 2'd3
  } special_e;

  // dst is the top field of every layout that has one
  typedef struct packed {
    logic [opd_width-1:0]              dst;
    logic [opd_width-1:0]              src_a;
    logic [opd_width-1:0]              src_b;
    logic [body_width-3*opd_width-1:0] pad;
  } rtype_s;

  typedef struct packed {
    logic [opd_width-1:0]                        dst;
    logic [imm16_width-1:0]                      imm;
    logic [body_width-opd_width-imm16_width-1:0] pad;
  } itype_s;

  typedef struct packed {
    logic [opd_width-1:0]                           src_a;
    logic [opd_width-1:0]                           src_b;
    logic [target_width-1:0]                        target;
    logic [body_width-2*opd_width-target_width-1:0] pad;
  } btype_s;

  typedef struct packed {
    logic [opd_width-1:0]                                      src_a;
    logic [imm8_width-1:0]                                     imm;
    logic [target_width-1:0]                                   target;
    logic [body_width-opd_width-imm8_width-target_width-1:0]   pad;
  } bitype_s;

  typedef struct packed {
    cce_op_e                op;
    logic [minor_width-1:0] minor_op;
    logic                   branch;
    logic                   predict_taken;
    logic [body_width-1:0]  body;
  } cce_inst_s;

endpackage
